// ==== list.f ====
logic/rv_isa_pkg.sv
logic/exe_pkg.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/pipe_reg.sv
logic/alu_fu.sv
logic/exe_core.sv
verif/exe_core_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = exe_core_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/exe_core_tb.sv ====
// random RV32 execute stream checked against a model of the ISA rules, NREGS fixed at 32
// a stray, missing or wrong writeback counts as an error; run length is bounded by loop counts
`timescale 1ns/1ps

module exe_core_tb;

   logic        clk;
   logic        rst;
   logic        instr_valid;
   logic [31:0] instr;
   logic [31:0] pc;
   logic        wb_valid;
   logic [4:0]  wb_rd;
   logic [31:0] wb_data;

   // model state and expected writebacks as {rd, data}
   logic [31:0] model_regs [32];
   logic [36:0] exp_q [$];

   string       test_name;
   int          err_count;
   int          test_err;
   int          tests_run;
   int          tests_failed;
   int          wb_count;
   int          check_count;

   exe_core #(.NREGS(32)) dut_i
   (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .pc          (pc),
      .wb_valid    (wb_valid),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data)
   );

   // 8 ns clock
   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // --------------------
   // output monitor
   // --------------------
   // outputs are registered, so the falling edge sees them settled
   always @(negedge clk)
   begin
      logic [36:0] e;
      if (!rst && wb_valid)
      begin
         wb_count++;
         if (exp_q.size() == 0)
         begin
            $display("unexpected writeback in %s: rd %0d data %h", test_name, wb_rd, wb_data);
            record_error();
         end
         else
         begin
            e = exp_q.pop_front();
            check_count++;
            if (wb_rd !== e[36:32])
            begin
               $display("FAILED %s rd: expected %0d, actual %0d", test_name, e[36:32], wb_rd);
               record_error();
            end
            if (wb_data !== e[31:0])
            begin
               $display("FAILED %s data: expected %h, actual %h", test_name, e[31:0], wb_data);
               record_error();
            end
         end
      end
   end

   task automatic record_error();
      err_count++;
      test_err++;
   endtask

   // --------------------
   // reference model
   // --------------------
   // RV32I semantics of one funct3 where alt picks SUB or SRA
   function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0:
            if (alt)
               return a - b;
            else
               return a + b;
         3'd1: return a << b[4:0];
         3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: return (a < b) ? 32'd1 : 32'd0;
         3'd4: return a ^ b;
         3'd5:
            if (alt)
               return $unsigned($signed(a) >>> b[4:0]);
            else
               return a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   // executes at issue time, so program order alone gives the forwarded values
   task automatic ref_execute(input logic [31:0] w, input logic [31:0] p);
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] imm;
      logic [31:0] res;
      logic        ok;
      f3  = w[14:12];
      f7  = w[31:25];
      rd  = w[11:7];
      a   = model_regs[w[19:15]];
      imm = {{20{w[31]}}, w[31:20]};
      ok  = 1'b1;
      res = '0;
      case (w[6:0])
         rv_isa_pkg::OPC_OP:
         begin
            ok  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            res = ref_alu(f3, f7[5], a, model_regs[w[24:20]]);
         end
         rv_isa_pkg::OPC_OP_IMM:
         begin
            if (f3 == 3'd1)
               ok = (f7 == 7'h00);
            else if (f3 == 3'd5)
               ok = (f7 == 7'h00) || (f7 == 7'h20);
            // no subtract form with an immediate
            res = ref_alu(f3, (f3 == 3'd5) && f7[5], a, imm);
         end
         rv_isa_pkg::OPC_LUI:   res = {w[31:12], 12'b0};
         rv_isa_pkg::OPC_AUIPC: res = p + {w[31:12], 12'b0};
         default:               ok = 1'b0;
      endcase
      if (ok)
      begin
         exp_q.push_back({rd, res});
         // x0 still writes back but keeps its zero
         if (rd != 5'd0)
            model_regs[rd] = res;
      end
   endtask

   // --------------------
   // stimulus helpers
   // --------------------
   function automatic logic [31:0] rand_alu_instr();
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      logic        alt;
      f3  = 3'($urandom());
      rd  = 5'($urandom());
      rs1 = 5'($urandom());
      rs2 = 5'($urandom());
      imm = 12'($urandom());
      alt = ($urandom() % 2 == 1);
      if ($urandom() % 2 == 0)
      begin
         // alt funct7 only where SUB or SRA exist
         f7 = (alt && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
         return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
      end
      // immediate shifts carry funct7 in imm[11:5]
      if (f3 == 3'd1)
         imm[11:5] = 7'h00;
      else if (f3 == 3'd5)
         imm[11:5] = alt ? 7'h20 : 7'h00;
      return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
   endfunction

   task automatic issue(input logic [31:0] w, input logic [31:0] p);
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= w;
      pc          <= p;
      ref_execute(w, p);
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      instr_valid <= 1'b0;
      // junk on the bus is ignored while the strobe is low
      instr       <= $urandom();
   endtask

   // bounded wait for all expected writebacks
   task automatic drain();
      int n;
      idle_cycle();
      n = 0;
      while ((exp_q.size() != 0) && (n < 20))
      begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0)
      begin
         $display("timeout in %s: %0d writebacks never arrived", test_name, exp_q.size());
         record_error();
         exp_q.delete();
      end
      // a few more cycles so extra writebacks show up here
      repeat (3) @(posedge clk);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err  = 0;
      tests_run++;
   endtask

   task automatic finish_test();
      drain();
      if (test_err == 0)
         $display("test %s: ok", test_name);
      else
      begin
         $display("test %s: %0d error(s)", test_name, test_err);
         tests_failed++;
      end
   endtask

   // --------------------
   // test sequence
   // --------------------
   initial
   begin
      logic [31:0] w;
      logic [31:0] p;
      logic [4:0]  prev;
      logic [4:0]  nxt;
      int          sel;
      int          kind;
      int          legal_issued;
      int          wb_start;

      void'($urandom(32'ha3d2));
      rst          = 1'b1;
      instr_valid  = 1'b0;
      instr        = '0;
      pc           = '0;
      err_count    = 0;
      test_err     = 0;
      tests_run    = 0;
      tests_failed = 0;
      wb_count     = 0;
      check_count  = 0;
      test_name    = "startup";
      for (int r = 0; r < 32; r++)
         model_regs[r] = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // quiet after reset, then OR every register with x0
      start_test("reset");
      for (int i = 0; i < 10; i++)
      begin
         @(negedge clk);
         if (wb_valid !== 1'b0)
         begin
            $display("wb_valid went high after reset with no instruction issued");
            record_error();
         end
      end
      for (int r = 0; r < 32; r++)
      begin
         issue({7'h00, 5'd0, 5'(r), 3'b110, 5'(r), rv_isa_pkg::OPC_OP}, 32'h0);
         idle_cycle();
      end
      finish_test();

      // fill registers with LUI + ADDI, then isolated random ops
      start_test("alu_random");
      for (int r = 1; r < 32; r++)
      begin
         issue({20'($urandom()), 5'(r), rv_isa_pkg::OPC_LUI}, 32'h0);
         idle_cycle();
         issue({12'($urandom()), 5'(r), 3'b000, 5'(r), rv_isa_pkg::OPC_OP_IMM}, 32'h0);
         idle_cycle();
      end
      for (int i = 0; i < 300; i++)
      begin
         issue(rand_alu_instr(), 32'h0);
         idle_cycle();
      end
      finish_test();

      start_test("lui_auipc");
      for (int i = 0; i < 60; i++)
      begin
         w      = $urandom();
         w[6:0] = ($urandom() % 2 == 0) ? rv_isa_pkg::OPC_LUI : rv_isa_pkg::OPC_AUIPC;
         p      = $urandom();
         p[1:0] = 2'b00;
         issue(w, p);
         idle_cycle();
      end
      finish_test();

      // dependent chains on consecutive cycles
      start_test("forwarding");
      for (int c = 0; c < 50; c++)
      begin
         prev = 5'(1 + $urandom_range(30));
         issue({20'($urandom()), prev, rv_isa_pkg::OPC_LUI}, 32'h0);
         for (int k = 0; k < 4; k++)
         begin
            w        = rand_alu_instr();
            nxt      = 5'(1 + $urandom_range(30));
            sel      = $urandom_range(2);
            w[11:7]  = nxt;
            // sel 0 hits rs1 only, 1 rs2 only and 2 both; OP-IMM has no rs2
            if ((w[6:0] == rv_isa_pkg::OPC_OP) && (sel != 0))
               w[24:20] = prev;
            if ((sel != 1) || (w[6:0] != rv_isa_pkg::OPC_OP))
               w[19:15] = prev;
            issue(w, 32'h0);
            prev = nxt;
         end
         idle_cycle();
      end
      finish_test();

      // ADDI to x0, then a read of x0 right behind it
      start_test("x0_write");
      for (int i = 0; i < 10; i++)
      begin
         w = {12'($urandom()), 5'($urandom()), 3'b000, 5'd0, rv_isa_pkg::OPC_OP_IMM};
         issue(w, 32'h0);
         nxt = 5'(1 + $urandom_range(30));
         issue({7'h00, 5'd0, 5'd0, 3'b110, nxt, rv_isa_pkg::OPC_OP}, 32'h0);
         idle_cycle();
      end
      finish_test();

      // loads, M extension and bad shift funct7 mixed with legal ops
      start_test("illegal");
      legal_issued = 0;
      wb_start     = wb_count;
      for (int i = 0; i < 60; i++)
      begin
         kind = $urandom_range(3);
         w    = $urandom();
         case (kind)
            0: w[6:0] = 7'b0000011;
            1:
            begin
               w[6:0]   = rv_isa_pkg::OPC_OP;
               w[31:25] = 7'h01;
            end
            2:
            begin
               w[6:0]   = rv_isa_pkg::OPC_OP_IMM;
               w[14:12] = 3'b001;
               w[31:25] = 7'h20;
            end
            default:
            begin
               w = rand_alu_instr();
               legal_issued++;
            end
         endcase
         issue(w, 32'h0);
         if ($urandom() % 2 == 0)
            idle_cycle();
      end
      drain();
      if ((wb_count - wb_start) != legal_issued)
      begin
         $display("FAILED %s writeback count: expected %0d, actual %0d",
                  test_name, legal_issued, wb_count - wb_start);
         record_error();
      end
      finish_test();

      $display("tests %0d, failed %0d, writebacks checked %0d, errors %0d",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== logic/exe_core.sv ====
// integer execute cluster, fixed 2-cycle latency, no stall or back-pressure
// illegal instructions are dropped in decode and never write back
`timescale 1ns/1ps

module exe_core
#(
   parameter int NREGS = 32
)
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            instr_valid,
   input  logic [31:0]                     instr,
   input  logic [31:0]                     pc,
   output logic                            wb_valid,
   output logic [exe_pkg::RIDX_W-1:0]      wb_rd,
   output logic [31:0]                     wb_data
);

   exe_pkg::alu_ctl_t              dec_ctl;
   logic [31:0]                    dec_imm;
   logic [exe_pkg::RIDX_W-1:0]     dec_rs1;
   logic [exe_pkg::RIDX_W-1:0]     dec_rs2;
   logic                           dec_legal;
   logic [31:0]                    rf_a;
   logic [31:0]                    rf_b;
   logic                           fwd_a;
   logic                           fwd_b;
   logic                           ex_wr;
   exe_pkg::id_ex_t                id_ex_d;
   exe_pkg::id_ex_t                id_ex_q;
   logic                           ex_valid;
   logic [31:0]                    alu_result;
   exe_pkg::wb_t                   ex_wb_d;
   exe_pkg::wb_t                   ex_wb_q;
   logic                           wb_vld_q;

   // --------------------
   // decode and operand read, cycle N
   // --------------------
   inst_decode dec_i
   (
      .instr  (instr),
      .ctl    (dec_ctl),
      .imm    (dec_imm),
      .rs1    (dec_rs1),
      .rs2    (dec_rs2),
      .legal  (dec_legal)
   );

   // EX writes the file this cycle, same condition drives forwarding
   assign ex_wr = ex_valid && id_ex_q.ctl.we;

   reg_file #(.NREGS(NREGS)) rf_i
   (
      .clk        (clk),
      .rst        (rst),
      .we         (ex_wr),
      .wr_addr    (id_ex_q.ctl.rd),
      .wr_data    (alu_result),
      .rd_addr_a  (dec_rs1),
      .rd_addr_b  (dec_rs2),
      .rd_data_a  (rf_a),
      .rd_data_b  (rf_b)
   );

   // bypass the value the file has not stored yet
   // x0 and out-of-range rd never forward, the file drops those writes
   assign fwd_a = ex_wr && (id_ex_q.ctl.rd == dec_rs1) && (dec_rs1 != '0) &&
                  exe_pkg::reg_in_range(dec_rs1, NREGS);
   assign fwd_b = ex_wr && (id_ex_q.ctl.rd == dec_rs2) && (dec_rs2 != '0) &&
                  exe_pkg::reg_in_range(dec_rs2, NREGS);

   always_comb
   begin
      id_ex_d.ctl      = dec_ctl;
      id_ex_d.rs1_data = fwd_a ? alu_result : rf_a;
      id_ex_d.rs2_data = fwd_b ? alu_result : rf_b;
      id_ex_d.imm      = dec_imm;
      id_ex_d.pc       = pc;
   end

   pipe_reg #(.payload_t(exe_pkg::id_ex_t)) id_ex_i
   (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (instr_valid && dec_legal),
      .in_data    (id_ex_d),
      .out_valid  (ex_valid),
      .out_data   (id_ex_q)
   );

   // --------------------
   // execute, cycle N+1
   // --------------------
   alu_fu alu_i
   (
      .ex     (id_ex_q),
      .result (alu_result)
   );

   always_comb
   begin
      ex_wb_d.we   = id_ex_q.ctl.we;
      ex_wb_d.rd   = id_ex_q.ctl.rd;
      ex_wb_d.data = alu_result;
   end

   pipe_reg #(.payload_t(exe_pkg::wb_t)) ex_wb_i
   (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (ex_valid),
      .in_data    (ex_wb_d),
      .out_valid  (wb_vld_q),
      .out_data   (ex_wb_q)
   );

   // writeback outputs, cycle N+2, straight from the register
   assign wb_valid = wb_vld_q && ex_wb_q.we;
   assign wb_rd    = ex_wb_q.rd;
   assign wb_data  = ex_wb_q.data;

endmodule

// ==== logic/alu_fu.sv ====
// ALU functional unit, zero-cycle combinational
// shift amounts use the low 5 bits of the y operand
`timescale 1ns/1ps

module alu_fu
(
   input  exe_pkg::id_ex_t                 ex,
   output logic [rv_isa_pkg::XLEN-1:0]     result
);

   logic [rv_isa_pkg::XLEN-1:0] mux_x;
   logic [rv_isa_pkg::XLEN-1:0] mux_y;

   // --------------------
   // operand muxes
   // --------------------
   always_comb
   begin
      case (ex.ctl.sel_x)
         rv_isa_pkg::AM_RS1: mux_x = ex.rs1_data;
         rv_isa_pkg::AM_RS2: mux_x = ex.rs2_data;
         rv_isa_pkg::AM_IMM: mux_x = ex.imm;
         default:            mux_x = ex.pc;
      endcase
   end

   always_comb
   begin
      case (ex.ctl.sel_y)
         rv_isa_pkg::AM_RS1: mux_y = ex.rs1_data;
         rv_isa_pkg::AM_RS2: mux_y = ex.rs2_data;
         rv_isa_pkg::AM_IMM: mux_y = ex.imm;
         default:            mux_y = ex.pc;
      endcase
   end

   // --------------------
   // function select
   // --------------------
   always_comb
   begin
      case (ex.ctl.op)
         rv_isa_pkg::A_AND:  result = mux_x & mux_y;
         // LUI lands here as x0 | imm
         rv_isa_pkg::A_OR:   result = mux_x | mux_y;
         rv_isa_pkg::A_XOR:  result = mux_x ^ mux_y;
         // AUIPC lands here as pc + imm
         rv_isa_pkg::A_ADD:  result = mux_x + mux_y;
         rv_isa_pkg::A_SUB:  result = mux_x - mux_y;
         rv_isa_pkg::A_SLL:  result = mux_x << mux_y[4:0];
         rv_isa_pkg::A_SRL:  result = mux_x >> mux_y[4:0];
         // arithmetic shift needs a signed left operand
         rv_isa_pkg::A_SRA:  result = $unsigned($signed(mux_x) >>> mux_y[4:0]);
         rv_isa_pkg::A_SLT:  result = ($signed(mux_x) < $signed(mux_y)) ? 32'd1 : 32'd0;
         rv_isa_pkg::A_SLTU: result = (mux_x < mux_y) ? 32'd1 : 32'd0;
         // unused encodings
         default:            result = '0;
      endcase
   end

endmodule

// ==== logic/pipe_reg.sv ====
// one pipeline stage: valid plus payload of any type
// payload holds its last value while no valid arrives
`timescale 1ns/1ps

module pipe_reg
#(
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data
);

   // stage valid, the only control state here
   always_ff @(posedge clk)
   begin
      if (rst)
         out_valid <= 1'b0;
      else
         out_valid <= in_valid;
   end

   // payload only loads with a valid, fewer toggles on idle cycles
   always_ff @(posedge clk)
   begin
      if (in_valid)
         out_data <= in_data;
   end

endmodule

// ==== logic/reg_file.sv ====
// 2 read / 1 write integer registers, reads are combinational
// with NREGS = 16, indices 16..31 read zero and drop their writes
`timescale 1ns/1ps

module reg_file
#(
   parameter int NREGS = 32
)
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            we,
   input  logic [exe_pkg::RIDX_W-1:0]      wr_addr,
   input  logic [31:0]                     wr_data,
   input  logic [exe_pkg::RIDX_W-1:0]      rd_addr_a,
   input  logic [exe_pkg::RIDX_W-1:0]      rd_addr_b,
   output logic [31:0]                     rd_data_a,
   output logic [31:0]                     rd_data_b
);

   // physical address width
   localparam int AW = exe_pkg::reg_addr_w(NREGS);

   logic [31:0] regs [NREGS];

   // x0 and out-of-range entries are never written
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < NREGS; i++)
            regs[i] <= '0;
      end
      else if (we && (wr_addr != '0) && exe_pkg::reg_in_range(wr_addr, NREGS))
         regs[wr_addr[AW-1:0]] <= wr_data;
   end

   // x0 stays zero at the read side too
   assign rd_data_a = ((rd_addr_a != '0) && exe_pkg::reg_in_range(rd_addr_a, NREGS)) ?
                      regs[rd_addr_a[AW-1:0]] : '0;
   assign rd_data_b = ((rd_addr_b != '0) && exe_pkg::reg_in_range(rd_addr_b, NREGS)) ?
                      regs[rd_addr_b[AW-1:0]] : '0;

endmodule

// ==== logic/inst_decode.sv ====
// decodes OP, OP-IMM, LUI and AUIPC only; anything else drops legal
// purely combinational, no pc input since AUIPC takes pc from the stage payload
`timescale 1ns/1ps

module inst_decode
(
   input  logic [31:0]                     instr,
   output exe_pkg::alu_ctl_t               ctl,
   output logic [31:0]                     imm,
   output logic [exe_pkg::RIDX_W-1:0]      rs1,
   output logic [exe_pkg::RIDX_W-1:0]      rs2,
   output logic                            legal
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   // instruction fields
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb
   begin
      // defaults: register-register form, nothing written
      ctl.op    = rv_isa_pkg::A_ADD;
      ctl.sel_x = rv_isa_pkg::AM_RS1;
      ctl.sel_y = rv_isa_pkg::AM_RS2;
      ctl.rd    = instr[11:7];
      imm       = '0;
      rs1       = instr[19:15];
      rs2       = '0;
      legal     = 1'b0;

      case (opcode)
         rv_isa_pkg::OPC_OP:
         begin
            rs2 = instr[24:20];
            // alt funct7 only exists for SUB and SRA
            legal = (funct7 == rv_isa_pkg::F7_BASE) ||
                    ((funct7 == rv_isa_pkg::F7_ALT) &&
                     ((funct3 == rv_isa_pkg::F3_ADD_SUB) ||
                      (funct3 == rv_isa_pkg::F3_SRL_SRA)));
         end
         rv_isa_pkg::OPC_OP_IMM:
         begin
            // I-type immediate, sign extended
            imm       = {{20{instr[31]}}, instr[31:20]};
            ctl.sel_y = rv_isa_pkg::AM_IMM;
            if (funct3 == rv_isa_pkg::F3_SLL)
               legal = (funct7 == rv_isa_pkg::F7_BASE);
            else if (funct3 == rv_isa_pkg::F3_SRL_SRA)
               legal = (funct7 == rv_isa_pkg::F7_BASE) || (funct7 == rv_isa_pkg::F7_ALT);
            else
               legal = 1'b1;
         end
         rv_isa_pkg::OPC_LUI:
         begin
            // x0 | imm, so rs1 forced to index 0
            imm       = {instr[31:12], 12'b0};
            rs1       = '0;
            ctl.op    = rv_isa_pkg::A_OR;
            ctl.sel_y = rv_isa_pkg::AM_IMM;
            legal     = 1'b1;
         end
         rv_isa_pkg::OPC_AUIPC:
         begin
            // pc + upper immediate
            imm       = {instr[31:12], 12'b0};
            rs1       = '0;
            ctl.op    = rv_isa_pkg::A_ADD;
            ctl.sel_x = rv_isa_pkg::AM_PC;
            ctl.sel_y = rv_isa_pkg::AM_IMM;
            legal     = 1'b1;
         end
         default:
            legal = 1'b0;
      endcase

      // shared funct3 map for OP and OP-IMM
      if ((opcode == rv_isa_pkg::OPC_OP) || (opcode == rv_isa_pkg::OPC_OP_IMM))
      begin
         case (funct3)
            rv_isa_pkg::F3_ADD_SUB:
               // OP-IMM has no subtract; bit 30 there is immediate
               ctl.op = (opcode == rv_isa_pkg::OPC_OP && funct7[5]) ?
                        rv_isa_pkg::A_SUB : rv_isa_pkg::A_ADD;
            rv_isa_pkg::F3_SLL:     ctl.op = rv_isa_pkg::A_SLL;
            rv_isa_pkg::F3_SLT:     ctl.op = rv_isa_pkg::A_SLT;
            rv_isa_pkg::F3_SLTU:    ctl.op = rv_isa_pkg::A_SLTU;
            rv_isa_pkg::F3_XOR:     ctl.op = rv_isa_pkg::A_XOR;
            rv_isa_pkg::F3_SRL_SRA: ctl.op = funct7[5] ? rv_isa_pkg::A_SRA : rv_isa_pkg::A_SRL;
            rv_isa_pkg::F3_OR:      ctl.op = rv_isa_pkg::A_OR;
            default:                ctl.op = rv_isa_pkg::A_AND;
         endcase
      end

      // every legal instruction in this subset writes rd
      ctl.we = legal;
   end

endmodule

// ==== logic/exe_pkg.sv ====
// stage payloads of the two-stage execute pipe
// register indices are always 5 bits wide, even for a 16-entry file

package exe_pkg;

   // architectural index width, fixed by the instruction format
   localparam int RIDX_W = 5;

   // address bits needed to index a file of nregs entries
   function automatic int reg_addr_w(input int nregs);
      return $clog2(nregs);
   endfunction

   // an index at or above nregs names no register (RV32E style)
   function automatic logic reg_in_range(input logic [RIDX_W-1:0] idx, input int nregs);
      return int'(idx) < nregs;
   endfunction

   // decoded ALU control, travels with the instruction into EX
   typedef struct packed {
      rv_isa_pkg::alu_op_t  op;
      rv_isa_pkg::alu_sel_t sel_x;
      rv_isa_pkg::alu_sel_t sel_y;
      logic                 we;
      logic [RIDX_W-1:0]    rd;
   } alu_ctl_t;

   // ID -> EX payload, operands already forwarded
   typedef struct packed {
      alu_ctl_t                       ctl;
      logic [rv_isa_pkg::XLEN-1:0]    rs1_data;
      logic [rv_isa_pkg::XLEN-1:0]    rs2_data;
      logic [rv_isa_pkg::XLEN-1:0]    imm;
      logic [rv_isa_pkg::XLEN-1:0]    pc;
   } id_ex_t;

   // EX -> WB payload
   typedef struct packed {
      logic                           we;
      logic [RIDX_W-1:0]              rd;
      logic [rv_isa_pkg::XLEN-1:0]    data;
   } wb_t;

endpackage

// ==== logic/rv_isa_pkg.sv ====
// RV32I integer subset only: OP, OP-IMM, LUI and AUIPC
// no M extension codes, no load/store/branch encodings

package rv_isa_pkg;

   // data and pc width
   localparam int XLEN = 32;

   // --------------------
   // major opcodes
   // --------------------
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

   // funct3 for OP and OP-IMM
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // funct7, alt form selects SUB and SRA
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   // --------------------
   // ALU control encodings
   // --------------------
   typedef enum logic [3:0] {
      A_AND,
      A_OR,
      A_XOR,
      A_ADD,
      A_SUB,
      A_SLL,
      A_SRL,
      A_SRA,
      A_SLT,
      A_SLTU
   } alu_op_t;

   // operand source for either ALU input
   typedef enum logic [1:0] {
      AM_RS1,
      AM_RS2,
      AM_IMM,
      AM_PC
   } alu_sel_t;

endpackage
